//--- all.f
tlb_reg_pkg.sv
tlb_entry_pkg.sv
tlb_ctrl.sv
tlb_entry_array.sv
tlb_probe.sv
tlb_lookup.sv
tlb_mmu_top.sv
tb_tlb_mmu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tlb_mmu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_tlb_mmu.sv
`timescale 1ns/1ps

module tb_tlb_mmu;
    import tlb_reg_pkg::*;

    localparam int TLB_NUM = 32;
    localparam int READY_TIMEOUT = 16;

    logic        clk;
    logic        rst;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] fetch_va;
    logic [31:0] fetch_pa;
    logic        fetch_miss;
    logic        fetch_valid;
    logic [31:0] data_va;
    logic [31:0] data_pa;
    logic        data_miss;
    logic        data_valid;
    logic        data_clean;

    // shadow table with tag and PFNs stored masked
    // sh_lo words keep C D V G in their low bits
    logic [11:0] sh_mask [TLB_NUM];
    logic [18:0] sh_vpn2 [TLB_NUM];
    logic [7:0]  sh_asid [TLB_NUM];
    logic [19:0] sh_pfn0 [TLB_NUM];
    logic [19:0] sh_pfn1 [TLB_NUM];
    logic [5:0]  sh_lo0 [TLB_NUM];
    logic [5:0]  sh_lo1 [TLB_NUM];
    logic [7:0]  cur_asid;
    logic [15:0] lfsr_state;

    tlb_mmu_top #(.TLB_NUM(TLB_NUM), .IDX_W(5)) tlb_mmu_top_inst (
        .clk(clk), .rst(rst),
        .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
        .pwrite_i(pwrite), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
        .fetch_va_i(fetch_va), .fetch_pa_o(fetch_pa),
        .fetch_miss_o(fetch_miss), .fetch_valid_o(fetch_valid),
        .data_va_i(data_va), .data_pa_o(data_pa), .data_miss_o(data_miss),
        .data_valid_o(data_valid), .data_clean_o(data_clean)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            stop_with_failure("a DUT output differs from its expected value");
        end
    endtask

    task automatic apb_transfer(input logic [7:0] addr, input logic write,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > READY_TIMEOUT) begin
                stop_with_failure("pready_o did not rise within the APB timeout");
            end
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(addr, 1'b1, data, rdata, err);
        check_value("pslverr_o", exp_err, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(addr, 1'b0, 32'h0, rdata, err);
        check_value("pslverr_o", 1'b0, err);
        check_value($sformatf("prdata_o at 0x%02h", addr), expected, rdata);
    endtask

    task automatic set_entryhi(input logic [31:0] value);
        apb_write(REG_ENTRYHI, value, 1'b0);
        cur_asid = value[7:0];
    endtask

    task automatic write_entry(input int idx, input logic [11:0] mask, input logic [31:0] ehi,
                               input logic [31:0] lo0, input logic [31:0] lo1);
        apb_write(REG_INDEX, 32'(idx), 1'b0);
        apb_write(REG_PAGEMASK, 32'(mask) << 13, 1'b0);
        set_entryhi(ehi);
        apb_write(REG_ENTRYLO0, lo0, 1'b0);
        apb_write(REG_ENTRYLO1, lo1, 1'b0);
        apb_write(REG_COMMAND, 32'(CMD_TLBWI), 1'b0);
        sh_mask[idx] = mask;
        sh_vpn2[idx] = ehi[31:13] & ~19'(mask);
        sh_asid[idx] = ehi[7:0];
        sh_pfn0[idx] = lo0[25:6] & ~20'(mask);
        sh_pfn1[idx] = lo1[25:6] & ~20'(mask);
        // global only when both halves say so
        sh_lo0[idx] = {lo0[5:1], lo0[0] & lo1[0]};
        sh_lo1[idx] = {lo1[5:1], lo0[0] & lo1[0]};
    endtask

    task automatic model_translate(input logic [31:0] va, output logic [31:0] pa,
                                   output logic miss, output logic valid, output logic clean);
        int          k;
        int          hits;
        logic        odd;
        logic [19:0] pfn;
        logic [5:0]  lo;
        pa = '0;
        miss = 1'b1;
        valid = 1'b0;
        clean = 1'b1;
        hits = 0;
        for (int e = 0; e < TLB_NUM; e++) begin
            k = $countones(sh_mask[e]);
            if ((va[31:13] >> k) == (sh_vpn2[e] >> k) &&
                    (sh_lo0[e][0] || sh_asid[e] == cur_asid)) begin
                hits++;
                odd = va[12 + k];
                pfn = odd ? sh_pfn1[e] : sh_pfn0[e];
                lo = odd ? sh_lo1[e] : sh_lo0[e];
                pfn = pfn & ~((20'd1 << k) - 20'd1);
                pa = (32'(pfn) << 12) | (va & ((32'd1 << (12 + k)) - 32'd1));
                miss = 1'b0;
                valid = lo[1];
                clean = !lo[2];
            end
        end
        if (hits > 1) begin
            stop_with_failure("two shadow entries cover the same virtual address");
        end
    endtask

    task automatic check_fetch(input logic [31:0] va);
        logic [31:0] pa;
        logic        miss;
        logic        valid;
        logic        clean;
        @(posedge clk);
        fetch_va <= va;
        @(negedge clk);
        model_translate(va, pa, miss, valid, clean);
        check_value("fetch_miss_o", miss, fetch_miss);
        check_value("fetch_pa_o", pa, fetch_pa);
        check_value("fetch_valid_o", valid, fetch_valid);
    endtask

    task automatic test_reset_and_registers();
        @(negedge clk);
        check_value("data_pa_o", 32'h0, data_pa);
        check_value("data_miss_o", 1'b0, data_miss);
        check_value("data_valid_o", 1'b0, data_valid);
        check_value("data_clean_o", 1'b0, data_clean);
        check_value("pslverr_o", 1'b0, pslverr);
        for (int a = 0; a <= 'h14; a += 4) begin
            apb_read(8'(a), 32'h0);
        end
        apb_write(REG_PAGEMASK, 32'hFFFF_FFFF, 1'b0);
        apb_read(REG_PAGEMASK, 32'h01FF_E000);
        apb_write(REG_ENTRYLO1, 32'h0ABC_DEF7, 1'b0);
        apb_read(REG_ENTRYLO1, 32'h0ABC_DEF7);
        apb_write(REG_INDEX, 32'd7, 1'b0);
        apb_write(REG_INDEX, 32'd32, 1'b1);
        apb_read(REG_INDEX, 32'd7);
        apb_write(REG_COMMAND, 32'd0, 1'b1);
        apb_write(8'h18, 32'h1, 1'b1);
    endtask

    task automatic test_write_read();
        // tag bits 14:13 and EntryHi bits 12:8 must not survive
        write_entry(5, 12'h003, 32'h4000_6F5A, 32'hFC00_003F | (random_bits(20) << 6),
                    32'h0000_002E | (random_bits(20) << 6));
        apb_write(REG_PAGEMASK, 32'h0, 1'b0);
        set_entryhi(32'h0);
        apb_write(REG_ENTRYLO0, 32'h0, 1'b0);
        apb_write(REG_ENTRYLO1, 32'h0, 1'b0);
        apb_write(REG_COMMAND, 32'(CMD_TLBR), 1'b0);
        cur_asid = sh_asid[5];
        apb_read(REG_INDEX, 32'd5);
        apb_read(REG_PAGEMASK, 32'(sh_mask[5]) << 13);
        apb_read(REG_ENTRYHI, {sh_vpn2[5], 5'b0, sh_asid[5]});
        apb_read(REG_ENTRYLO0, {6'b0, sh_pfn0[5], sh_lo0[5]});
        apb_read(REG_ENTRYLO1, {6'b0, sh_pfn1[5], sh_lo1[5]});
    endtask

    task automatic test_small_pages();
        write_entry(1, 12'h000, 32'h0040_005A, (random_bits(20) << 6) | 32'h06,
                    (random_bits(20) << 6) | 32'h02);
        // even page of entry 2 has V clear
        write_entry(2, 12'h000, 32'h0080_005A, (random_bits(20) << 6) | 32'h04,
                    (random_bits(20) << 6) | 32'h06);
        check_fetch(32'h0040_0123);
        check_fetch(32'h0040_1ABC);
        check_fetch(32'h0040_2000);
        check_fetch(32'h0080_0456);
        check_fetch(32'h0080_1FFF);
    endtask

    task automatic test_large_pages();
        write_entry(3, 12'h003, 32'h1000_005A, (random_bits(20) << 6) | 32'h06,
                    (random_bits(20) << 6) | 32'h02);
        write_entry(4, 12'h0FF, 32'h2000_005A, (random_bits(20) << 6) | 32'h02,
                    (random_bits(20) << 6) | 32'h06);
        for (int n = 0; n < 16; n++) begin
            check_fetch(32'h1000_0000 | random_bits(15));
            check_fetch(32'h2000_0000 | random_bits(21));
        end
    endtask

    task automatic test_asid_and_probe();
        logic [31:0] rdata;
        logic        err;
        write_entry(6, 12'h000, 32'h3000_005A, 32'h0000_0406, 32'h0000_0806);
        write_entry(7, 12'h000, 32'h3100_0011, 32'h0000_0C07, 32'h0000_1007);
        write_entry(8, 12'h000, 32'h3200_0022, 32'h0000_1407, 32'h0000_1806);
        for (int pass = 0; pass < 2; pass++) begin
            set_entryhi(pass == 0 ? 32'h5A : 32'h33);
            check_fetch(32'h3000_0ABC);
            check_fetch(32'h3100_1123);
            check_fetch(32'h3200_0456);
        end
        set_entryhi(32'h3000_005A);
        apb_write(REG_COMMAND, 32'(CMD_TLBP), 1'b0);
        apb_read(REG_INDEX, 32'd6);
        set_entryhi(32'h3100_0033);
        apb_write(REG_COMMAND, 32'(CMD_TLBP), 1'b0);
        apb_read(REG_INDEX, 32'd7);
        set_entryhi(32'h3000_0033);
        apb_write(REG_COMMAND, 32'(CMD_TLBP), 1'b0);
        apb_transfer(REG_INDEX, 1'b0, 32'h0, rdata, err);
        check_value("pslverr_o", 1'b0, err);
        check_value("prdata_o[31] after probe miss", 1'b1, rdata[PROBE_FAIL_BIT]);
        apb_write(REG_INDEX, 32'd6, 1'b0);
        apb_read(REG_INDEX, 32'd6);
    endtask

    task automatic test_data_port();
        logic [31:0] vas [12];
        logic [31:0] exp_pa [12];
        logic        exp_miss [12];
        logic        exp_valid [12];
        logic        exp_clean [12];
        set_entryhi(32'h5A);
        for (int n = 0; n < 12; n++) begin
            case (n % 4)
                0: vas[n] = 32'h0040_0000 | random_bits(13);
                1: vas[n] = 32'h1000_0000 | random_bits(15);
                2: vas[n] = 32'h2000_0000 | random_bits(21);
                default: vas[n] = 32'h6000_0000 | random_bits(16);
            endcase
            model_translate(vas[n], exp_pa[n], exp_miss[n], exp_valid[n], exp_clean[n]);
        end
        @(posedge clk);
        data_va <= 32'h7000_0000;
        for (int n = 0; n <= 12; n++) begin
            @(posedge clk);
            if (n < 12) begin
                data_va <= vas[n];
            end
            @(negedge clk);
            if (n == 0) begin
                // still the unmapped VA from the cycle before
                check_value("data_miss_o", 1'b1, data_miss);
            end else begin
                check_value("data_miss_o", exp_miss[n-1], data_miss);
                check_value("data_pa_o", exp_pa[n-1], data_pa);
                check_value("data_valid_o", exp_valid[n-1], data_valid);
                if (!exp_miss[n-1]) begin
                    check_value("data_clean_o", exp_clean[n-1], data_clean);
                end
            end
        end
    endtask

    initial begin
        rst      = 1'b1;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        fetch_va = '0;
        data_va  = '0;
        cur_asid = '0;
        lfsr_state = 16'd33173;
        for (int e = 0; e < TLB_NUM; e++) begin
            sh_mask[e] = '0;
            sh_vpn2[e] = '0;
            sh_asid[e] = '0;
            sh_pfn0[e] = '0;
            sh_pfn1[e] = '0;
            sh_lo0[e]  = '0;
            sh_lo1[e]  = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_reset_and_registers();
        test_write_read();
        test_small_pages();
        test_large_pages();
        test_asid_and_probe();
        test_data_port();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- tlb_mmu_top.sv
`timescale 1ns/1ps

module tlb_mmu_top #(
    parameter int TLB_NUM = 32,
    parameter int IDX_W = 5
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  paddr_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    input  logic [31:0] fetch_va_i,
    output logic [31:0] fetch_pa_o,
    output logic        fetch_miss_o,
    output logic        fetch_valid_o,
    input  logic [31:0] data_va_i,
    output logic [31:0] data_pa_o,
    output logic        data_miss_o,
    output logic        data_valid_o,
    output logic        data_clean_o
);
    import tlb_entry_pkg::*;

    logic                       wr_en;
    logic [IDX_W-1:0]           index;
    logic [MASK_W-1:0]          mask;
    logic [31:0]                entryhi;
    logic [31:0]                entrylo0;
    logic [31:0]                entrylo1;
    logic [MASK_W-1:0]          rd_mask;
    logic [31:0]                rd_entryhi;
    logic [31:0]                rd_entrylo0;
    logic [31:0]                rd_entrylo1;
    logic                       probe_hit;
    logic [IDX_W-1:0]           probe_index;
    logic [TLB_NUM*MASK_W-1:0]  mask_v;
    logic [TLB_NUM*VPN2_W-1:0]  vpn2_v;
    logic [TLB_NUM*ASID_W-1:0]  asid_v;
    logic [TLB_NUM*PFN_W-1:0]   pfn0_v;
    logic [TLB_NUM*PFN_W-1:0]   pfn1_v;
    logic [TLB_NUM-1:0]         g_v;
    logic [TLB_NUM-1:0]         d0_v;
    logic [TLB_NUM-1:0]         d1_v;
    logic [TLB_NUM-1:0]         v0_v;
    logic [TLB_NUM-1:0]         v1_v;

    tlb_ctrl #(.TLB_NUM(TLB_NUM), .IDX_W(IDX_W)) tlb_ctrl_inst (
        .clk(clk), .rst(rst),
        .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .wr_en_o(wr_en), .index_o(index), .mask_o(mask),
        .entryhi_o(entryhi), .entrylo0_o(entrylo0), .entrylo1_o(entrylo1),
        .rd_mask_i(rd_mask), .rd_entryhi_i(rd_entryhi),
        .rd_entrylo0_i(rd_entrylo0), .rd_entrylo1_i(rd_entrylo1),
        .probe_hit_i(probe_hit), .probe_index_i(probe_index)
    );

    tlb_entry_array #(.TLB_NUM(TLB_NUM), .IDX_W(IDX_W)) tlb_entry_array_inst (
        .clk(clk), .rst(rst),
        .wr_en_i(wr_en), .index_i(index), .mask_i(mask),
        .entryhi_i(entryhi), .entrylo0_i(entrylo0), .entrylo1_i(entrylo1),
        .rd_mask_o(rd_mask), .rd_entryhi_o(rd_entryhi),
        .rd_entrylo0_o(rd_entrylo0), .rd_entrylo1_o(rd_entrylo1),
        .mask_v_o(mask_v), .vpn2_v_o(vpn2_v), .asid_v_o(asid_v), .g_v_o(g_v),
        .pfn0_v_o(pfn0_v), .pfn1_v_o(pfn1_v), .d0_v_o(d0_v), .d1_v_o(d1_v),
        .v0_v_o(v0_v), .v1_v_o(v1_v)
    );

    tlb_probe #(.TLB_NUM(TLB_NUM), .IDX_W(IDX_W)) tlb_probe_inst (
        .entryhi_i(entryhi), .mask_v_i(mask_v), .vpn2_v_i(vpn2_v),
        .asid_v_i(asid_v), .g_v_i(g_v), .v0_v_i(v0_v), .v1_v_i(v1_v),
        .probe_hit_o(probe_hit), .probe_index_o(probe_index)
    );

    // fetch port, combinational
    tlb_lookup #(.TLB_NUM(TLB_NUM), .OUT_REG(0)) tlb_lookup_fetch_inst (
        .clk(clk), .rst(rst), .va_i(fetch_va_i), .asid_i(entryhi[ASID_W-1:0]),
        .mask_v_i(mask_v), .vpn2_v_i(vpn2_v), .asid_v_i(asid_v), .g_v_i(g_v),
        .pfn0_v_i(pfn0_v), .pfn1_v_i(pfn1_v), .d0_v_i(d0_v), .d1_v_i(d1_v),
        .v0_v_i(v0_v), .v1_v_i(v1_v),
        .pa_o(fetch_pa_o), .miss_o(fetch_miss_o), .valid_o(fetch_valid_o), .clean_o()
    );

    // data port, one register stage
    tlb_lookup #(.TLB_NUM(TLB_NUM), .OUT_REG(1)) tlb_lookup_data_inst (
        .clk(clk), .rst(rst), .va_i(data_va_i), .asid_i(entryhi[ASID_W-1:0]),
        .mask_v_i(mask_v), .vpn2_v_i(vpn2_v), .asid_v_i(asid_v), .g_v_i(g_v),
        .pfn0_v_i(pfn0_v), .pfn1_v_i(pfn1_v), .d0_v_i(d0_v), .d1_v_i(d1_v),
        .v0_v_i(v0_v), .v1_v_i(v1_v),
        .pa_o(data_pa_o), .miss_o(data_miss_o), .valid_o(data_valid_o),
        .clean_o(data_clean_o)
    );

endmodule

//--- tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup #(
    parameter int TLB_NUM = 32,
    parameter int OUT_REG = 0
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [31:0]                              va_i,
    input  logic [tlb_entry_pkg::ASID_W-1:0]         asid_i,
    input  logic [TLB_NUM*tlb_entry_pkg::MASK_W-1:0] mask_v_i,
    input  logic [TLB_NUM*tlb_entry_pkg::VPN2_W-1:0] vpn2_v_i,
    input  logic [TLB_NUM*tlb_entry_pkg::ASID_W-1:0] asid_v_i,
    input  logic [TLB_NUM-1:0]                       g_v_i,
    input  logic [TLB_NUM*tlb_entry_pkg::PFN_W-1:0]  pfn0_v_i,
    input  logic [TLB_NUM*tlb_entry_pkg::PFN_W-1:0]  pfn1_v_i,
    input  logic [TLB_NUM-1:0]                       d0_v_i,
    input  logic [TLB_NUM-1:0]                       d1_v_i,
    input  logic [TLB_NUM-1:0]                       v0_v_i,
    input  logic [TLB_NUM-1:0]                       v1_v_i,
    output logic [31:0]                              pa_o,
    output logic                                     miss_o,
    output logic                                     valid_o,
    output logic                                     clean_o
);
    import tlb_entry_pkg::*;

    logic [TLB_NUM-1:0] match;
    logic [TLB_NUM-1:0] odd;
    logic [TLB_NUM-1:0] v_sel;
    logic [TLB_NUM-1:0] d_sel;
    logic [31:0]        pa_e [TLB_NUM];
    logic [31:0]        pa_c;

    for (genvar i = 0; i < TLB_NUM; i++) begin : g_entry
        logic [MASK_W-1:0] m;
        logic [PFN_W-1:0]  pfn;

        assign m = mask_v_i[i*MASK_W +: MASK_W];
        assign match[i] = ((va_i[31:EHI_VPN2_LSB] ^ vpn2_v_i[i*VPN2_W +: VPN2_W])
                           & ~VPN2_W'(m)) == '0
                          && (g_v_i[i] || asid_v_i[i*ASID_W +: ASID_W] == asid_i);
        // VA bit 12+k picks the odd page
        assign odd[i] = ^(va_i[OFFSET_W +: MASK_W+1] & ({m, 1'b1} ^ {1'b0, m}));
        assign pfn    = odd[i] ? pfn1_v_i[i*PFN_W +: PFN_W] : pfn0_v_i[i*PFN_W +: PFN_W];
        assign v_sel[i] = odd[i] ? v1_v_i[i] : v0_v_i[i];
        assign d_sel[i] = odd[i] ? d1_v_i[i] : d0_v_i[i];
        // stored PFN is already masked
        assign pa_e[i] = {pfn, {OFFSET_W{1'b0}}} | (va_i & 32'({m, {OFFSET_W{1'b1}}}));
    end

    always_comb begin
        pa_c = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (match[i]) begin
                pa_c = pa_c | pa_e[i];
            end
        end
    end

    if (OUT_REG != 0) begin : g_out_reg
        always_ff @(posedge clk) begin
            if (rst) begin
                pa_o    <= '0;
                miss_o  <= 1'b0;
                valid_o <= 1'b0;
                clean_o <= 1'b0;
            end else begin
                pa_o    <= pa_c;
                miss_o  <= ~|match;
                valid_o <= |(match & v_sel);
                clean_o <= ~|(match & d_sel);
            end
        end
    end else begin : g_out_comb
        assign pa_o    = pa_c;
        assign miss_o  = ~|match;
        assign valid_o = |(match & v_sel);
        assign clean_o = ~|(match & d_sel);
    end

endmodule

//--- tlb_probe.sv
`timescale 1ns/1ps

module tlb_probe #(
    parameter int TLB_NUM = 32,
    parameter int IDX_W = 5
) (
    input  logic [31:0]                              entryhi_i,
    input  logic [TLB_NUM*tlb_entry_pkg::MASK_W-1:0] mask_v_i,
    input  logic [TLB_NUM*tlb_entry_pkg::VPN2_W-1:0] vpn2_v_i,
    input  logic [TLB_NUM*tlb_entry_pkg::ASID_W-1:0] asid_v_i,
    input  logic [TLB_NUM-1:0]                       g_v_i,
    input  logic [TLB_NUM-1:0]                       v0_v_i,
    input  logic [TLB_NUM-1:0]                       v1_v_i,
    output logic                                     probe_hit_o,
    output logic [IDX_W-1:0]                         probe_index_o
);
    import tlb_entry_pkg::*;

    logic [TLB_NUM-1:0] match;

    for (genvar i = 0; i < TLB_NUM; i++) begin : g_cmp
        assign match[i] =
            ((entryhi_i[EHI_VPN2_LSB +: VPN2_W] ^ vpn2_v_i[i*VPN2_W +: VPN2_W])
             & ~VPN2_W'(mask_v_i[i*MASK_W +: MASK_W])) == '0
            && (g_v_i[i] || asid_v_i[i*ASID_W +: ASID_W] == entryhi_i[ASID_W-1:0]);
    end

    // OR of the indices, exact while a single entry matches
    always_comb begin
        probe_index_o = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (match[i]) begin
                probe_index_o = probe_index_o | IDX_W'(i);
            end
        end
    end

    assign probe_hit_o = |match;

    // cleared entries all alias, so only mapped ones count
    a_single_match: assert final ($onehot0(match & (v0_v_i | v1_v_i)))
        else $error("more than one mapped entry matches EntryHi");

endmodule

//--- tlb_entry_array.sv
`timescale 1ns/1ps

module tlb_entry_array #(
    parameter int TLB_NUM = 32,
    parameter int IDX_W = 5
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     wr_en_i,
    input  logic [IDX_W-1:0]                         index_i,
    input  logic [tlb_entry_pkg::MASK_W-1:0]         mask_i,
    input  logic [31:0]                              entryhi_i,
    input  logic [31:0]                              entrylo0_i,
    input  logic [31:0]                              entrylo1_i,
    output logic [tlb_entry_pkg::MASK_W-1:0]         rd_mask_o,
    output logic [31:0]                              rd_entryhi_o,
    output logic [31:0]                              rd_entrylo0_o,
    output logic [31:0]                              rd_entrylo1_o,
    output logic [TLB_NUM*tlb_entry_pkg::MASK_W-1:0] mask_v_o,
    output logic [TLB_NUM*tlb_entry_pkg::VPN2_W-1:0] vpn2_v_o,
    output logic [TLB_NUM*tlb_entry_pkg::ASID_W-1:0] asid_v_o,
    output logic [TLB_NUM-1:0]                       g_v_o,
    output logic [TLB_NUM*tlb_entry_pkg::PFN_W-1:0]  pfn0_v_o,
    output logic [TLB_NUM*tlb_entry_pkg::PFN_W-1:0]  pfn1_v_o,
    output logic [TLB_NUM-1:0]                       d0_v_o,
    output logic [TLB_NUM-1:0]                       d1_v_o,
    output logic [TLB_NUM-1:0]                       v0_v_o,
    output logic [TLB_NUM-1:0]                       v1_v_o
);
    import tlb_entry_pkg::*;

    logic [MASK_W-1:0]  mask_q [TLB_NUM];
    logic [VPN2_W-1:0]  vpn2_q [TLB_NUM];
    logic [ASID_W-1:0]  asid_q [TLB_NUM];
    logic [PFN_W-1:0]   pfn0_q [TLB_NUM];
    logic [PFN_W-1:0]   pfn1_q [TLB_NUM];
    logic [ELO_C_W-1:0] c0_q   [TLB_NUM];
    logic [ELO_C_W-1:0] c1_q   [TLB_NUM];
    logic [TLB_NUM-1:0] g_q;
    logic [TLB_NUM-1:0] d0_q;
    logic [TLB_NUM-1:0] d1_q;
    logic [TLB_NUM-1:0] v0_q;
    logic [TLB_NUM-1:0] v1_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < TLB_NUM; n++) begin
                mask_q[n] <= '0;
                vpn2_q[n] <= '0;
                asid_q[n] <= '0;
                pfn0_q[n] <= '0;
                pfn1_q[n] <= '0;
                c0_q[n]   <= '0;
                c1_q[n]   <= '0;
            end
            g_q  <= '0;
            d0_q <= '0;
            d1_q <= '0;
            v0_q <= '0;
            v1_q <= '0;
        end else if (wr_en_i) begin
            // bits under the mask are dropped
            mask_q[index_i]  <= mask_i;
            vpn2_q[index_i]  <= entryhi_i[EHI_VPN2_LSB +: VPN2_W] & ~VPN2_W'(mask_i);
            asid_q[index_i]  <= entryhi_i[ASID_W-1:0];
            pfn0_q[index_i]  <= entrylo0_i[ELO_PFN_LSB +: PFN_W] & ~PFN_W'(mask_i);
            pfn1_q[index_i]  <= entrylo1_i[ELO_PFN_LSB +: PFN_W] & ~PFN_W'(mask_i);
            c0_q[index_i]    <= entrylo0_i[ELO_C_LSB +: ELO_C_W];
            c1_q[index_i]    <= entrylo1_i[ELO_C_LSB +: ELO_C_W];
            g_q[index_i]     <= entrylo0_i[ELO_G_BIT] & entrylo1_i[ELO_G_BIT];
            d0_q[index_i]    <= entrylo0_i[ELO_D_BIT];
            d1_q[index_i]    <= entrylo1_i[ELO_D_BIT];
            v0_q[index_i]    <= entrylo0_i[ELO_V_BIT];
            v1_q[index_i]    <= entrylo1_i[ELO_V_BIT];
        end
    end

    // read-out for TLBR, zero padded
    assign rd_mask_o     = mask_q[index_i];
    assign rd_entryhi_o  = {vpn2_q[index_i], {(EHI_VPN2_LSB-ASID_W){1'b0}}, asid_q[index_i]};
    assign rd_entrylo0_o = {{(32-ELO_PFN_LSB-PFN_W){1'b0}}, pfn0_q[index_i], c0_q[index_i],
                            d0_q[index_i], v0_q[index_i], g_q[index_i]};
    assign rd_entrylo1_o = {{(32-ELO_PFN_LSB-PFN_W){1'b0}}, pfn1_q[index_i], c1_q[index_i],
                            d1_q[index_i], v1_q[index_i], g_q[index_i]};

    for (genvar i = 0; i < TLB_NUM; i++) begin : g_flat
        assign mask_v_o[i*MASK_W +: MASK_W] = mask_q[i];
        assign vpn2_v_o[i*VPN2_W +: VPN2_W] = vpn2_q[i];
        assign asid_v_o[i*ASID_W +: ASID_W] = asid_q[i];
        assign pfn0_v_o[i*PFN_W +: PFN_W]   = pfn0_q[i];
        assign pfn1_v_o[i*PFN_W +: PFN_W]   = pfn1_q[i];
    end

    assign g_v_o  = g_q;
    assign d0_v_o = d0_q;
    assign d1_v_o = d1_q;
    assign v0_v_o = v0_q;
    assign v1_v_o = v1_q;

    a_wr_index_range: assert property (@(posedge clk) disable iff (rst)
        wr_en_i |-> index_i < TLB_NUM)
        else $error("table write with index beyond the entry count");

endmodule

//--- tlb_ctrl.sv
`timescale 1ns/1ps

module tlb_ctrl #(
    parameter int TLB_NUM = 32,
    parameter int IDX_W = 5
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [7:0]                        paddr_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [31:0]                       pwdata_i,
    output logic [31:0]                       prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    output logic                              wr_en_o,
    output logic [IDX_W-1:0]                  index_o,
    output logic [tlb_entry_pkg::MASK_W-1:0]  mask_o,
    output logic [31:0]                       entryhi_o,
    output logic [31:0]                       entrylo0_o,
    output logic [31:0]                       entrylo1_o,
    input  logic [tlb_entry_pkg::MASK_W-1:0]  rd_mask_i,
    input  logic [31:0]                       rd_entryhi_i,
    input  logic [31:0]                       rd_entrylo0_i,
    input  logic [31:0]                       rd_entrylo1_i,
    input  logic                              probe_hit_i,
    input  logic [IDX_W-1:0]                  probe_index_i
);
    import tlb_reg_pkg::*;
    import tlb_entry_pkg::*;

    logic              access;
    logic              bad_addr;
    logic              bad_wdata;
    logic              wr_ok;
    logic [1:0]        cmd;
    logic [IDX_W-1:0]  index_q;
    logic              probe_fail_q;
    logic [MASK_W-1:0] pagemask_q;
    logic [31:0]       entryhi_q;
    logic [31:0]       entrylo0_q;
    logic [31:0]       entrylo1_q;

    // no wait states
    assign access   = psel_i && penable_i;
    assign pready_o = access;
    assign cmd      = pwdata_i[1:0];

    always_comb begin
        bad_addr = 1'b0;
        prdata_o = '0;
        case (paddr_i)
            REG_INDEX: begin
                prdata_o = 32'(index_q) | (32'(probe_fail_q) << PROBE_FAIL_BIT);
            end
            REG_PAGEMASK: prdata_o = 32'(pagemask_q) << PM_MASK_LSB;
            REG_ENTRYHI:  prdata_o = entryhi_q;
            REG_ENTRYLO0: prdata_o = entrylo0_q;
            REG_ENTRYLO1: prdata_o = entrylo1_q;
            // command register reads as zero
            REG_COMMAND:  prdata_o = '0;
            default:      bad_addr = 1'b1;
        endcase
    end

    assign bad_wdata = pwrite_i &&
        ((paddr_i == REG_COMMAND && cmd == 2'd0) ||
         (paddr_i == REG_INDEX && pwdata_i >= 32'(TLB_NUM)));
    assign pslverr_o = access && (bad_addr || bad_wdata);
    assign wr_ok     = access && pwrite_i && !pslverr_o;
    assign wr_en_o   = wr_ok && paddr_i == REG_COMMAND && cmd == CMD_TLBWI;

    always_ff @(posedge clk) begin
        if (rst) begin
            index_q      <= '0;
            probe_fail_q <= 1'b0;
            pagemask_q   <= '0;
            entryhi_q    <= '0;
            entrylo0_q   <= '0;
            entrylo1_q   <= '0;
        end else if (wr_ok) begin
            case (paddr_i)
                REG_INDEX: begin
                    index_q      <= pwdata_i[IDX_W-1:0];
                    probe_fail_q <= 1'b0;
                end
                REG_PAGEMASK: pagemask_q <= pwdata_i[PM_MASK_LSB +: MASK_W];
                REG_ENTRYHI:  entryhi_q  <= pwdata_i;
                REG_ENTRYLO0: entrylo0_q <= pwdata_i;
                REG_ENTRYLO1: entrylo1_q <= pwdata_i;
                REG_COMMAND: begin
                    if (cmd == CMD_TLBR) begin
                        pagemask_q <= rd_mask_i;
                        entryhi_q  <= rd_entryhi_i;
                        entrylo0_q <= rd_entrylo0_i;
                        entrylo1_q <= rd_entrylo1_i;
                    end else if (cmd == CMD_TLBP) begin
                        // on a miss the encoded index is 0
                        index_q      <= probe_index_i;
                        probe_fail_q <= !probe_hit_i;
                    end
                end
                default: ;
            endcase
        end
    end

    assign index_o    = index_q;
    assign mask_o     = pagemask_q;
    assign entryhi_o  = entryhi_q;
    assign entrylo0_o = entrylo0_q;
    assign entrylo1_o = entrylo1_q;

    a_setup_before_access: assert property (@(posedge clk) disable iff (rst)
        (psel_i && penable_i) |-> $past(psel_i && !penable_i))
        else $error("APB access phase without a setup phase");

endmodule

//--- tlb_entry_pkg.sv
package tlb_entry_pkg;

    // entry field widths
    localparam int VPN2_W = 19;
    localparam int ASID_W = 8;
    localparam int PFN_W  = 20;
    localparam int MASK_W = 12;

    // EntryHi and PageMask
    localparam int EHI_VPN2_LSB = 13;
    localparam int PM_MASK_LSB  = 13;
    localparam int OFFSET_W     = 12;

    // EntryLo fields
    localparam int ELO_PFN_LSB = 6;
    localparam int ELO_C_LSB   = 3;
    localparam int ELO_C_W     = 3;
    localparam int ELO_D_BIT   = 2;
    localparam int ELO_V_BIT   = 1;
    localparam int ELO_G_BIT   = 0;

endpackage

//--- tlb_reg_pkg.sv
package tlb_reg_pkg;

    // register byte offsets, 8-bit APB address space
    localparam logic [7:0] REG_INDEX    = 8'h00;
    localparam logic [7:0] REG_PAGEMASK = 8'h04;
    localparam logic [7:0] REG_ENTRYHI  = 8'h08;
    localparam logic [7:0] REG_ENTRYLO0 = 8'h0C;
    localparam logic [7:0] REG_ENTRYLO1 = 8'h10;
    localparam logic [7:0] REG_COMMAND  = 8'h14;

    // command codes, low two bits of a command write
    localparam logic [1:0] CMD_TLBWI = 2'd1;
    localparam logic [1:0] CMD_TLBR  = 2'd2;
    localparam logic [1:0] CMD_TLBP  = 2'd3;

    // probe miss flag within Index
    localparam int PROBE_FAIL_BIT = 31;

endpackage
